/* verif/mipsTrace.txt */
// @000 program words, @020 initial data memory, @030 number of rows
// @040 rows: irAddr rfWriteEn rfWriteAddr rfWriteData memOp(0 none 1 sw 2 lw) memAddr memData
@000
8C010000 8C020004 8C030008 00222020 // lw r1, lw r2, lw r3, add r4
00222822 00623024 00243825 0041402A // sub r5, and r6, or r7, slt r8
0022482A 00015100 00025F02 AC070010 // slt r9, sll r10, srl r11, sw r7
8C0C0010 00210020 00016820 102D0002 // lw r12, add r0, add r13 from r0, beq taken
00217020 00217020 10220005 0C000016 // two skipped, beq not taken, jal 0x58
08000018 00217020 00857020 03E00008 // j 0x60, skipped, add r14, jr r31
01CC7820 FC000000 0800001A          // add r15, undefined opcode, j self
@020
00000005 FFFFFFFD 0F0F00FF 00000000
@030
00000018
@040
00000004 1 01 00000005 2 00 00000000 // 00 lw r1
00000008 1 02 FFFFFFFD 2 01 00000000 // 04 lw r2
0000000C 1 03 0F0F00FF 2 02 00000000 // 08 lw r3
00000010 1 04 00000002 0 00 00000000 // 0C add
00000014 1 05 00000008 0 00 00000000 // 10 sub
00000018 1 06 0F0F00FD 0 00 00000000 // 14 and
0000001C 1 07 00000007 0 00 00000000 // 18 or
00000020 1 08 00000001 0 00 00000000 // 1C slt negative operand
00000024 1 09 00000000 0 00 00000000 // 20 slt false
00000028 1 0A 00000050 0 00 00000000 // 24 sll
0000002C 1 0B 0000000F 0 00 00000000 // 28 srl
00000030 0 00 00000000 1 04 00000007 // 2C sw
00000034 1 0C 00000007 2 04 00000000 // 30 lw readback
00000038 0 00 00000000 0 00 00000000 // 34 write to r0
0000003C 1 0D 00000005 0 00 00000000 // 38 r0 as source
00000048 0 00 00000000 0 00 00000000 // 3C beq taken
0000004C 0 00 00000000 0 00 00000000 // 48 beq not taken
00000058 1 1F 00000050 0 00 00000000 // 4C jal
0000005C 1 0E 0000000A 0 00 00000000 // 58 add
00000050 0 00 00000000 0 00 00000000 // 5C jr
00000060 0 00 00000000 0 00 00000000 // 50 j
00000064 1 0F 00000011 0 00 00000000 // 60 add
00000068 0 00 00000000 0 00 00000000 // 64 undefined opcode
00000068 0 00 00000000 0 00 00000000 // 68 j self

/* singleCycleMips.f */
+incdir+hdl
hdl/mipsPkg.sv
hdl/controlUnit.sv
hdl/pcUnit.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/singleCycleMips.sv
verif/mipsTb.sv

/* Makefile */
# Verilator build and run of the single-cycle MIPS testbench
VERILATOR ?= verilator
TOP       ?= mipsTb
FILELIST  ?= singleCycleMips.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* verif/mipsTb.sv */
// Testbench for the single-cycle MIPS core with trace-driven memories and per-cycle checks
`timescale 1ns/1ps
`default_nettype none

module mipsTb;

  // ====================
  // trace layout
  // ====================
  localparam int IMEM_WORDS  = 32;
  localparam int DMEM_WORDS  = 128;   // 7-bit word address
  localparam int TRACE_WORDS = 256;
  localparam int DATA_BASE   = 32;    // initial data memory words
  localparam int DATA_WORDS  = 4;
  localparam int COUNT_AT    = 48;    // number of expectation rows
  localparam int ROW_BASE    = 64;
  localparam int ROW_WORDS   = 7;
  localparam int MAX_ROWS    = (TRACE_WORDS - ROW_BASE) / ROW_WORDS;
  localparam int PERIOD      = 100;   // ns

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] ir;
  logic [31:0] irAddr;
  logic [31:0] memReadData;
  logic        cen;
  logic        wen;
  logic        oen;
  logic [6:0]  memAddr;
  logic [31:0] memWriteData;
  logic        rfWriteEn;
  logic [4:0]  rfWriteAddr;
  logic [31:0] rfWriteData;

  logic [31:0] traceMem [0:TRACE_WORDS-1];  // raw file image
  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];

  int          numRows;
  int          errors;
  int          checks;
  logic        storePending;  // last row was a store
  logic [6:0]  storeAddr;
  logic [31:0] storeData;

  singleCycleMips UUT (
    .clk(clk), .rst(rst), .ir(ir), .irAddr(irAddr),
    .memReadData(memReadData), .cen(cen), .wen(wen), .oen(oen),
    .memAddr(memAddr), .memWriteData(memWriteData),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
  );

  always #(PERIOD / 2) clk = ~clk;

  // ====================
  // memory models
  // ====================
  // synchronous fetch returning word 0 in reset
  always @(posedge clk) begin
    ir <= rst ? imem[0] : imem[irAddr[6:2]];
  end

  assign memReadData = (!cen && !oen) ? dmem[memAddr] : 32'h0;  // async read

  always @(posedge clk) begin
    if (!cen && !wen) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  function automatic logic [31:0] traceWord(input int idx);
    traceWord = traceMem[idx[7:0]];
  endfunction

  task loadMemories();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i[4:0]] = traceWord(i);
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i[6:0]] <= {16'hD0D0, 9'd0, i[6:0]};  // tagged with its own address
    end
    for (i = 0; i < DATA_WORDS; i++) begin
      dmem[i[6:0]] <= traceWord(DATA_BASE + i);
    end
  endtask

  // ====================
  // checking
  // ====================
  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // one trace row against the instruction now on ir
  task automatic checkRow(input int row);
    int          base;
    logic [31:0] memOp;
    base  = ROW_BASE + row * ROW_WORDS;
    memOp = traceWord(base + 4);  // 0 none, 1 store, 2 load
    if (storePending) begin
      checkValue("dmem", dmem[storeAddr], storeData);  // previous sw landed
    end
    checkValue("irAddr", irAddr, traceWord(base));
    checkValue("rfWriteEn", {31'd0, rfWriteEn}, traceWord(base + 1));
    if (traceWord(base + 1) != 32'd0) begin
      checkValue("rfWriteAddr", {27'd0, rfWriteAddr}, traceWord(base + 2));
      checkValue("rfWriteData", rfWriteData, traceWord(base + 3));
    end
    checkValue("cen", {31'd0, cen}, {31'd0, memOp == 32'd0});
    checkValue("wen", {31'd0, wen}, {31'd0, memOp != 32'd1});
    checkValue("oen", {31'd0, oen}, {31'd0, memOp != 32'd2});
    if (memOp != 32'd0) begin
      checkValue("memAddr", {25'd0, memAddr}, traceWord(base + 5));
    end
    if (memOp == 32'd1) begin
      checkValue("memWriteData", memWriteData, traceWord(base + 6));
    end
    storePending = (memOp == 32'd1);
    storeAddr    = 7'(traceWord(base + 5));
    storeData    = traceWord(base + 6);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int row;
    errors       = 0;
    checks       = 0;
    storePending = 1'b0;
    storeAddr    = '0;
    storeData    = '0;
    $readmemh("verif/mipsTrace.txt", traceMem);
    loadMemories();
    numRows = int'(traceWord(COUNT_AT));
    rst     <= 1'b1;
    ir      <= imem[0];  // word 0 visible during reset
    if (numRows < 1 || numRows > MAX_ROWS) begin
      $display("trace row count %0d is out of range, no rows checked", numRows);
      errors++;
      numRows = 0;
    end
    @(posedge clk);
    @(negedge clk);
    checkValue("irAddr", irAddr, 32'h0);  // fetch address held in reset
    @(posedge clk);
    rst <= 1'b0;  // two cycles of reset
    for (row = 0; row < numRows; row++) begin
      @(negedge clk);  // outputs settled mid-cycle
      checkRow(row);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog sized by the trace length plus slack
  initial begin
    #1;
    #((numRows + 10) * PERIOD);
    $display("run timed out before all %0d trace rows were checked", numRows);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/singleCycleMips.sv */
// Single-cycle MIPS top level tying the control unit and datapath to the memory ports
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips (
  input  logic              clk,
  input  logic              rst,
  // instruction fetch
  input  mipsPkg::word_t    ir,
  output mipsPkg::word_t    irAddr,
  // data memory with active-low strobes
  input  mipsPkg::word_t    memReadData,
  output logic              cen,
  output logic              wen,
  output logic              oen,
  output mipsPkg::memAddr_t memAddr,
  output mipsPkg::word_t    memWriteData,
  // register writeback observation
  output logic              rfWriteEn,
  output mipsPkg::regAddr_t rfWriteAddr,
  output mipsPkg::word_t    rfWriteData
);

  // ====================
  // instruction fields
  // ====================
  mipsPkg::regAddr_t rsAddr;
  mipsPkg::regAddr_t rtAddr;
  mipsPkg::regAddr_t rdAddr;
  logic [15:0]       immField;
  logic [4:0]        shamt;
  logic [25:0]       jumpTarget;

  assign rsAddr     = ir[25:21];
  assign rtAddr     = ir[20:16];
  assign rdAddr     = ir[15:11];
  assign immField   = ir[15:0];
  assign shamt      = ir[10:6];
  assign jumpTarget = ir[25:0];

  // controls
  logic              regDst;
  logic              aluSrc;
  logic              memToReg;
  logic              regWrite;
  logic              memRead;
  logic              memWrite;
  logic              branch;
  logic              jump;
  logic              jumpReg;
  logic              link;
  logic              shiftOp;
  mipsPkg::aluCtrl_t aluCtrl;

  // datapath
  mipsPkg::word_t pc;
  mipsPkg::word_t nextPc;
  mipsPkg::word_t rsData;
  mipsPkg::word_t rtData;
  mipsPkg::word_t imm;
  mipsPkg::word_t aluResult;
  logic           zero;

  controlUnit uCtrl (
    .ir(ir), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .branch(branch), .jump(jump), .jumpReg(jumpReg), .link(link),
    .shiftOp(shiftOp), .aluCtrl(aluCtrl)
  );

  pcUnit uPc (
    .clk(clk), .rst(rst), .imm(imm), .jumpTarget(jumpTarget), .rsData(rsData),
    .branch(branch), .zero(zero), .jump(jump), .jumpReg(jumpReg),
    .pc(pc), .nextPc(nextPc)
  );

  regFile uRf (
    .clk(clk), .rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(rdAddr),
    .regWrite(regWrite), .regDst(regDst), .link(link), .memToReg(memToReg),
    .aluResult(aluResult), .memReadData(memReadData), .pc(pc),
    .rsData(rsData), .rtData(rtData), .writeEn(rfWriteEn),
    .writeAddr(rfWriteAddr), .writeData(rfWriteData)
  );

  executeUnit uExe (
    .rsData(rsData), .rtData(rtData), .immField(immField), .shamt(shamt),
    .aluSrc(aluSrc), .shiftOp(shiftOp), .aluCtrl(aluCtrl),
    .imm(imm), .result(aluResult), .zero(zero)
  );

  // ====================
  // memory ports
  // ====================
  assign irAddr       = rst ? '0 : nextPc;  // sync imem fetches word 0 in reset
  assign cen          = ~(memRead | memWrite);
  assign wen          = ~memWrite;          // sw only
  assign oen          = ~memRead;           // lw only
  assign memAddr      = aluResult[8:2];     // word address
  assign memWriteData = rtData;

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
// Sign extension, operand selection and ALU with zero flag
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module executeUnit (
  input  mipsPkg::word_t    rsData,
  input  mipsPkg::word_t    rtData,
  input  logic [15:0]       immField,  // ir[15:0]
  input  logic [4:0]        shamt,     // ir[10:6]
  input  logic              aluSrc,
  input  logic              shiftOp,
  input  mipsPkg::aluCtrl_t aluCtrl,
  output mipsPkg::word_t    imm,
  output mipsPkg::word_t    result,
  output logic              zero
);

  mipsPkg::word_t opA;
  mipsPkg::word_t opB;

  assign imm = {{16{immField[15]}}, immField};

  // ====================
  // operands
  // ====================
  assign opA = shiftOp ? rtData : rsData;  // shifts act on rt
  assign opB = aluSrc ? imm : rtData;

  always_comb begin
    case (aluCtrl)
      `ALU_ADD: result = opA + opB;
      `ALU_SUB: result = opA - opB;
      `ALU_AND: result = opA & opB;
      `ALU_OR:  result = opA | opB;
      `ALU_SLT: result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      `ALU_SLL: result = opA << shamt;
      `ALU_SRL: result = opA >> shamt;  // logical shift with zero fill
      default:  result = '0;            // ALU_NOP
    endcase
  end

  // beq compares through the subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/regFile.sv */
// Register file with writeback address and data selection where r0 reads as zero
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module regFile (
  input  logic              clk,
  input  mipsPkg::regAddr_t rsAddr,
  input  mipsPkg::regAddr_t rtAddr,
  input  mipsPkg::regAddr_t rdAddr,
  input  logic              regWrite,
  input  logic              regDst,
  input  logic              link,
  input  logic              memToReg,
  input  mipsPkg::word_t    aluResult,
  input  mipsPkg::word_t    memReadData,
  input  mipsPkg::word_t    pc,
  output mipsPkg::word_t    rsData,
  output mipsPkg::word_t    rtData,
  output logic              writeEn,    // real write this cycle
  output mipsPkg::regAddr_t writeAddr,
  output mipsPkg::word_t    writeData
);

  mipsPkg::word_t regs [1:31];  // r0 has no storage
  mipsPkg::word_t returnAddr;

  assign returnAddr = pc + 32'd4;  // no delay slot

  // ====================
  // writeback selection
  // ====================
  always_comb begin
    if (link) begin
      writeAddr = `LINK_REG;
      writeData = returnAddr;
    end else begin
      writeAddr = regDst ? rdAddr : rtAddr;
      writeData = memToReg ? memReadData : aluResult;  // lw or ALU
    end
  end

  // writes to r0 dropped
  assign writeEn = regWrite && (writeAddr != 5'd0);

  always_ff @(posedge clk) begin
    if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports return the old value on a same-cycle write
  // ====================
  assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

/* hdl/pcUnit.sv */
// Program counter with next-address selection for sequential, branch and jump flow
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  logic           clk,
  input  logic           rst,
  input  mipsPkg::word_t imm,         // sign-extended offset
  input  logic [25:0]    jumpTarget,  // ir[25:0]
  input  mipsPkg::word_t rsData,      // jr target
  input  logic           branch,
  input  logic           zero,
  input  logic           jump,
  input  logic           jumpReg,
  output mipsPkg::word_t pc,          // address of current ir
  output mipsPkg::word_t nextPc
);

  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t branchAddr;
  mipsPkg::word_t jumpAddr;

  assign pcPlus4    = pc + 32'd4;
  assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};     // word offset
  assign jumpAddr   = {pcPlus4[31:28], jumpTarget, 2'b00};  // same 256MB region

  // ====================
  // next address with highest priority first
  // ====================
  always_comb begin
    if (jumpReg) begin
      nextPc = rsData;
    end else if (jump) begin
      nextPc = jumpAddr;
    end else if (branch && zero) begin
      nextPc = branchAddr;  // beq taken
    end else begin
      nextPc = pcPlus4;
    end
  end

  // one instruction per edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
// Main decoder and ALU-control decoder mapping the instruction word to datapath controls
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module controlUnit (
  input  mipsPkg::word_t    ir,
  output logic              regDst,    // rd when high, else rt
  output logic              aluSrc,    // immediate as operand B
  output logic              memToReg,  // writeback from memory
  output logic              regWrite,
  output logic              memRead,
  output logic              memWrite,
  output logic              branch,
  output logic              jump,
  output logic              jumpReg,   // jr
  output logic              link,      // jal writes pc+4 to r31
  output logic              shiftOp,   // sll/srl take rt as operand A
  output mipsPkg::aluCtrl_t aluCtrl
);

  mipsPkg::opcode_t opcode;
  mipsPkg::funct_t  funct;

  assign opcode = ir[31:26];
  assign funct  = ir[5:0];

  always_comb begin
    // defaults write nothing and touch no memory
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    jumpReg  = 1'b0;
    link     = 1'b0;
    shiftOp  = 1'b0;
    aluCtrl  = `ALU_NOP;

    case (opcode)
      `OP_RTYPE: begin
        regDst   = 1'b1;
        regWrite = 1'b1;  // cleared below for jr and unknown funct
        case (funct)
          `FN_ADD: aluCtrl = `ALU_ADD;
          `FN_SUB: aluCtrl = `ALU_SUB;
          `FN_AND: aluCtrl = `ALU_AND;
          `FN_OR:  aluCtrl = `ALU_OR;
          `FN_SLT: aluCtrl = `ALU_SLT;
          `FN_SLL: begin
            aluCtrl = `ALU_SLL;
            shiftOp = 1'b1;
          end
          `FN_SRL: begin
            aluCtrl = `ALU_SRL;
            shiftOp = 1'b1;
          end
          `FN_JR: begin
            jumpReg  = 1'b1;
            regWrite = 1'b0;  // jr writes nothing
          end
          default: begin
            regDst   = 1'b0;  // unknown funct acts as no-op
            regWrite = 1'b0;
          end
        endcase
      end
      `OP_LW: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        aluCtrl  = `ALU_ADD;  // base + offset
      end
      `OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluCtrl  = `ALU_ADD;
      end
      `OP_BEQ: begin
        branch  = 1'b1;
        aluCtrl = `ALU_SUB;  // zero flag on equal
      end
      `OP_J:   jump = 1'b1;
      `OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;  // undefined opcode keeps all controls low
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mipsPkg.sv */
// Shared vector types for the single-cycle MIPS datapath
`default_nettype none

package mipsPkg;

  // ====================
  // datapath widths
  // ====================
  typedef logic [31:0] word_t;     // data, address or instruction
  typedef logic [4:0]  regAddr_t;  // register index

  // instruction fields
  typedef logic [5:0] opcode_t;    // ir[31:26]
  typedef logic [5:0] funct_t;     // ir[5:0]

  // ALU operation select using the ALU_* encodings
  typedef logic [3:0] aluCtrl_t;

  // data memory word address from byte address bits 8:2
  typedef logic [6:0] memAddr_t;

endpackage

`default_nettype wire

/* hdl/mips_defines.svh */
// MIPS subset encodings for opcodes, funct codes, ALU operations and sizes
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ====================
// opcodes in ir[31:26]
// ====================
`define OP_RTYPE 6'b000000   // funct decides
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ====================
// funct codes in ir[5:0]
// ====================
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_SLL   6'b000000   // also the all-zero nop
`define FN_SRL   6'b000010
`define FN_JR    6'b001000

// ====================
// ALU operations
// ====================
`define ALU_AND  4'b0000
`define ALU_OR   4'b0001
`define ALU_ADD  4'b0010
`define ALU_SUB  4'b0110
`define ALU_SLT  4'b0111
`define ALU_SLL  4'b1000
`define ALU_SRL  4'b1001
`define ALU_NOP  4'b1111     // result forced to zero

// misc sizes
`define LINK_REG   5'd31     // jal return address
`define DMEM_WORDS 128       // data memory depth with 7-bit word address

`endif
